//--- filelist.f
verilog/privPkg.sv
verilog/privDec.sv
verilog/trapCtrl.sv
verilog/privState.sv
verilog/privUnit.sv
test/tbClock.sv
test/privUnit_assert.sv
test/privUnitTb.sv

//--- Makefile
TOP = privUnitTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f verilog/*.sv test/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

lint:
	verilator --lint-only -Wall --top-module privUnit verilog/privPkg.sv \
		verilog/privDec.sv verilog/trapCtrl.sv verilog/privState.sv verilog/privUnit.sv

clean:
	rm -rf obj_dir sim.log

//--- test/privUnitTb.sv
`timescale 1ns/1ps

module privUnitTb import privPkg::*; ();

  localparam int wfiBit = 3;  // default wfiTimeoutBit of the DUT
  // bits 31:15 of each SYSTEM encoding
  localparam sysFieldT encEcall   = {12'h000, 5'd0};
  localparam sysFieldT encEbreak  = {12'h001, 5'd0};
  localparam sysFieldT encMret    = {12'h302, 5'd0};
  localparam sysFieldT encSret    = {12'h102, 5'd0};
  localparam sysFieldT encWfi     = {12'h105, 5'd0};
  localparam sysFieldT encSfence  = {7'h09, 10'd0};
  localparam sysFieldT encSinval  = {7'h0b, 10'd0};
  localparam sysFieldT encWInval  = {12'h180, 5'd0};
  localparam sysFieldT encInvalIr = {12'h181, 5'd0};
  // sret last since it drops out of M
  localparam sysFieldT knownEnc [10] = '{encEcall, encEbreak, encMret, encWfi, encSfence,
    encSinval, encWInval, encInvalIr, {12'h000, 5'd9}, encSret};

  typedef struct packed {
    logic  trap;
    causeT cause;
    logic  mret;
    logic  sret;
    logic  wfi;
    logic  sfenceVma;
  } expectT;

  logic       clk, rstN;
  sysFieldT   sysField;
  logic       privileged, illegalIeu, illegalCsr, statusWe;
  privStatusT statusWrData;
  privModeT   privMode;
  privStatusT status;
  logic       trap, mret, sret, wfi, sfenceVma;
  causeT      cause, mcause;

  // reference state, mirrors privState and the wfi counter
  privModeT   refMode;
  privStatusT refStatus;
  causeT      refMcause;
  int         refWfiCnt;
  expectT     expNow;
  int         errCount = 0;
  int         errMark = 0;
  int         checkCount = 0;

  tbClock uClock (.clk(clk), .rstN(rstN));

  privUnit UUT (.*);

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic expectT expectOut(sysFieldT f, logic p, logic ieu, logic csr,
                                       privModeT mode, privStatusT st, int wfiCnt);
    expectT e;
    logic   rs1Z;
    logic   isEcall, isEbreak, timeout, illegal;
    rs1Z     = (f[19:15] == 5'd0);
    isEcall  = p && rs1Z && f[31:20] == 12'h000;
    isEbreak = p && rs1Z && f[31:20] == 12'h001;
    e.mret   = p && rs1Z && f[31:20] == 12'h302 && mode == mMode;  // M only
    e.sret   = p && rs1Z && f[31:20] == 12'h102 && (mode == mMode || (mode == sMode && !st.tsr));
    e.wfi    = p && rs1Z && f[31:20] == 12'h105;
    e.sfenceVma = p && (f[31:25] == 7'h09 || f[31:25] == 7'h0b ||
                  (rs1Z && (f[31:20] == 12'h180 || f[31:20] == 12'h181))) &&
                  (mode == mMode || (mode == sMode && !st.tvm));
    timeout = e.wfi && wfiCnt[wfiBit] && ((st.tw && mode != mMode) || mode == uMode);
    illegal = ieu || csr || timeout ||
              (p && !(isEcall || isEbreak || e.mret || e.sret || e.wfi || e.sfenceVma));
    e.trap  = illegal || isEcall || isEbreak;
    if (illegal) e.cause = causeIllegal;  // illegal beats ecall
    else if (isEcall) e.cause = (mode == uMode) ? causeEcallU :
                                (mode == sMode) ? causeEcallS : causeEcallM;
    else if (isEbreak) e.cause = causeBreakpoint;
    else e.cause = '0;
    return e;
  endfunction

  task automatic checkField(string name, logic [7:0] got, logic [7:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // compare just before state moves, then step the model
  always @(posedge clk) begin
    if (!rstN) begin
      refMode = mMode;
      refStatus = '0;
      refStatus.mpp = mMode;
      refMcause = '0;
      refWfiCnt = 0;
    end else begin
      expNow = expectOut(sysField, privileged, illegalIeu, illegalCsr, refMode, refStatus,
                         refWfiCnt);
      checkField("trap", 8'(trap), 8'(expNow.trap));
      if (expNow.trap) checkField("cause", 8'(cause), 8'(expNow.cause));  // don't care otherwise
      checkField("mret", 8'(mret), 8'(expNow.mret));
      checkField("sret", 8'(sret), 8'(expNow.sret));
      checkField("wfi", 8'(wfi), 8'(expNow.wfi));
      checkField("sfenceVma", 8'(sfenceVma), 8'(expNow.sfenceVma));
      checkField("privMode", 8'(privMode), 8'(refMode));
      checkField("status", 8'(status), 8'(refStatus));
      checkField("mcause", 8'(mcause), 8'(refMcause));
      if (expNow.trap) begin
        refMcause = expNow.cause;
        refStatus.mpp = refMode;
        refMode = mMode;
      end else if (expNow.mret) begin
        refMode = refStatus.mpp;
        refStatus.mpp = uMode;
      end else if (expNow.sret) begin
        refMode = refStatus.spp ? sMode : uMode;
        refStatus.spp = 1'b0;
      end else if (statusWe) begin
        refStatus = statusWrData;
      end
      refWfiCnt = expNow.wfi ? (refWfiCnt + 1) % (2 << wfiBit) : 0;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic driveCycle(sysFieldT f, logic p, logic ieu, logic csr, logic we,
                            privStatusT wd);
    @(negedge clk);
    sysField = f;
    privileged = p;
    illegalIeu = ieu;
    illegalCsr = csr;
    statusWe = we;
    statusWrData = wd;
  endtask

  task automatic issueInstr(sysFieldT f);
    driveCycle(f, 1'b1, 1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic idleCycle();
    driveCycle('0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic writeStatus(privStatusT wd);
    driveCycle('0, 1'b0, 1'b0, 1'b0, 1'b1, wd);
  endtask

  // trap up to M if needed, load mpp, mret down
  task automatic gotoMode(privModeT m, logic tsr, logic tvm, logic tw);
    idleCycle();
    if (privMode != mMode) issueInstr(encEcall);
    writeStatus('{mpp: m, spp: 1'b0, tsr: tsr, tvm: tvm, tw: tw});
    issueInstr(encMret);
    idleCycle();
  endtask

  task automatic finishTest(string name);
    $display("test %s: %0d errors", name, errCount - errMark);
    errMark = errCount;
  endtask

  initial begin
    int          n;
    logic [31:0] r;
    logic        sawTrap;
    sysFieldT    f;
    privStatusT  wd;
    void'($urandom(31));
    sysField = '0;
    privileged = 1'b0;
    illegalIeu = 1'b0;
    illegalCsr = 1'b0;
    statusWe = 1'b0;
    statusWrData = '0;
    n = 0;
    while (rstN !== 1'b1 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (rstN !== 1'b1) begin
      $display("reset was not released within 10 cycles");
      $display("TEST FAILED");
      $finish;
    end

    // M mode decode, all forms
    foreach (knownEnc[i]) issueInstr(knownEnc[i]);
    idleCycle();
    finishTest("m-mode decode");

    gotoMode(sMode, 1'b1, 1'b1, 1'b0);
    issueInstr(encMret);    // mret from S
    gotoMode(sMode, 1'b1, 1'b1, 1'b0);
    issueInstr(encSret);    // TSR set
    gotoMode(sMode, 1'b1, 1'b1, 1'b0);
    issueInstr(encSfence);  // TVM set
    gotoMode(sMode, 1'b0, 1'b0, 1'b0);
    issueInstr(encSret);    // legal, spp 0 drops to U
    issueInstr(encSfence);  // never from U
    gotoMode(uMode, 1'b0, 1'b0, 1'b0);
    issueInstr(encMret);
    idleCycle();
    finishTest("mode enforcement");

    gotoMode(uMode, 1'b0, 1'b0, 1'b0);
    issueInstr(encEcall);
    idleCycle();
    checkField("privMode", 8'(privMode), 8'(mMode));
    checkField("status.mpp", 8'(status.mpp), 8'(uMode));
    checkField("mcause", 8'(mcause), 8'(causeEcallU));
    issueInstr(encMret);
    idleCycle();
    checkField("privMode", 8'(privMode), 8'(uMode));
    issueInstr(encEcall);  // back to M
    writeStatus('{mpp: mMode, spp: 1'b1, tsr: 1'b0, tvm: 1'b0, tw: 1'b0});
    issueInstr(encSret);
    idleCycle();
    checkField("privMode", 8'(privMode), 8'(sMode));
    finishTest("trap and return");

    gotoMode(uMode, 1'b0, 1'b0, 1'b0);
    n = 0;
    sawTrap = 1'b0;
    while (!sawTrap && n < 20) begin
      issueInstr(encWfi);
      @(posedge clk);
      sawTrap = trap;
      n++;
    end
    if (!sawTrap) begin
      errCount++;
      $display("no wfi timeout trap within 20 cycles in U mode");
    end else checkField("wfiCycles", 8'(n), 8'd9);
    gotoMode(mMode, 1'b0, 1'b0, 1'b0);
    sawTrap = 1'b0;
    for (n = 0; n < 20; n++) begin
      issueInstr(encWfi);
      @(posedge clk);
      sawTrap |= trap;
    end
    if (sawTrap) begin
      errCount++;
      $display("wfi in M mode with TW clear raised a trap");
    end
    idleCycle();
    finishTest("wfi timeout");

    for (n = 0; n < 300; n++) begin
      r = $urandom;
      f = (r[1:0] != 2'd0) ? knownEnc[int'(r[5:2]) % 10] : sysFieldT'($urandom);
      wd = privStatusT'(r[26:20]);
      if (wd.mpp == 2'd2) wd.mpp = mMode;  // reserved level
      // upstream never flags a legal mret
      driveCycle(f, r[8:6] != 3'd0, r[12:9] == 4'd0 && f != encMret,
                 r[16:13] == 4'd0 && f != encMret, r[19:17] == 3'd0, wd);
    end
    idleCycle();
    finishTest("random stream");

    $display("checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- test/privUnit_assert.sv
`timescale 1ns/1ps

module privUnit_assert import privPkg::*; (
  input logic     clk,
  input logic     rstN,
  input logic     trap,
  input logic     mret,
  input logic     wfi,
  input logic     sfenceVma,
  input privModeT privMode
);

  ////////////////////////////////////////
  // top-level output properties
  ////////////////////////////////////////

  // an mret never retires in a trapping cycle
  trapNotMret: assert property (@(posedge clk) disable iff (!rstN) !(trap && mret))
    else $error("trap and mret high in the same cycle");

  trapToM: assert property (@(posedge clk) disable iff (!rstN) trap |=> privMode == mMode)
    else $error("privilege mode is not M after a trap");  // every trap lands in M

  // distinct encodings, never both
  wfiNotSfence: assert property (@(posedge clk) disable iff (!rstN) !(wfi && sfenceVma))
    else $error("wfi and sfenceVma high in the same cycle");

endmodule

bind privUnit privUnit_assert uPrivAssert (.*);

//--- test/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int resetCycles = 3  // rising edges seen with reset low
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

//--- verilog/privUnit.sv
`timescale 1ns/1ps

module privUnit import privPkg::*; #(
  parameter bit sSupported       = 1'b1,
  parameter bit uSupported       = 1'b1,
  parameter bit svinvalSupported = 1'b1,
  parameter int wfiTimeoutBit    = 3   // timeout after 2^n + 1 wfi cycles
) (
  input  logic       clk,
  input  logic       rstN,
  input  sysFieldT   sysField,
  input  logic       privileged,
  input  logic       illegalIeu,
  input  logic       illegalCsr,
  input  logic       statusWe,
  input  privStatusT statusWrData,
  output privModeT   privMode,
  output privStatusT status,
  output logic       trap,
  output causeT      cause,
  output causeT      mcause,
  output logic       mret,
  output logic       sret,
  output logic       wfi,
  output logic       sfenceVma
);

  privFaultT fault;  // decoder to trap control

  ////////////////////////////////////////
  // decode, trap, state
  ////////////////////////////////////////

  privDec #(
    .sSupported       (sSupported),
    .uSupported       (uSupported),
    .svinvalSupported (svinvalSupported),
    .wfiTimeoutBit    (wfiTimeoutBit)
  ) uPrivDec (
    .clk        (clk),
    .rstN       (rstN),
    .sysField   (sysField),
    .privileged (privileged),
    .illegalIeu (illegalIeu),
    .illegalCsr (illegalCsr),
    .privMode   (privMode),
    .status     (status),
    .fault      (fault),
    .mret       (mret),
    .sret       (sret),
    .wfi        (wfi),
    .sfenceVma  (sfenceVma)
  );

  trapCtrl uTrapCtrl (
    .clk      (clk),
    .rstN     (rstN),
    .fault    (fault),
    .privMode (privMode),
    .trap     (trap),
    .cause    (cause),
    .mcause   (mcause)
  );

  privState #(
    .sSupported (sSupported),
    .uSupported (uSupported)
  ) uPrivState (
    .clk          (clk),
    .rstN         (rstN),
    .trap         (trap),
    .mret         (mret),
    .sret         (sret),
    .statusWe     (statusWe),
    .statusWrData (statusWrData),
    .privMode     (privMode),
    .status       (status)
  );

endmodule

//--- verilog/privState.sv
`timescale 1ns/1ps

module privState import privPkg::*; #(
  parameter bit sSupported = 1'b1,
  parameter bit uSupported = 1'b1
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic       trap,          // trap taken this cycle
  input  logic       mret,          // legal mret retiring
  input  logic       sret,          // legal sret retiring
  input  logic       statusWe,      // CSR write to the status fields
  input  privStatusT statusWrData,
  output privModeT   privMode,
  output privStatusT status
);

  privStatusT wrLegal;    // write data after WARL fixups
  privModeT   mretMpp;    // mpp value left behind by mret
  privModeT   sretMode;   // mode entered by sret

  ////////////////////////////////////////
  // write legalization
  ////////////////////////////////////////

  always_comb begin
    wrLegal = statusWrData;
    if (!sSupported) begin
      wrLegal.spp = 1'b0;  // no S mode to return to
      if (statusWrData.mpp == sMode)
        wrLegal.mpp = status.mpp;  // drop S, keep the old level
    end
  end

  assign mretMpp  = uSupported ? uMode : mMode;  // least privileged level we have
  assign sretMode = status.spp ? sMode : uMode;

  ////////////////////////////////////////
  // mode and status registers
  ////////////////////////////////////////

  // trap > mret > sret > csr write
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      privMode   <= mMode;  // boot in M
      status     <= '0;
      status.mpp <= mMode;
    end else if (trap) begin
      status.mpp <= privMode;  // remember where we came from
      privMode   <= mMode;
    end else if (mret) begin
      privMode   <= status.mpp;
      status.mpp <= mretMpp;
    end else if (sret) begin
      privMode   <= sretMode;
      status.spp <= 1'b0;
    end else if (statusWe) begin
      status <= wrLegal;  // tsr, tvm, tw pass straight through
    end
  end

endmodule

//--- verilog/trapCtrl.sv
`timescale 1ns/1ps

module trapCtrl import privPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  privFaultT fault,     // decoded faults of this cycle
  input  privModeT  privMode,  // mode the instruction runs in
  output logic      trap,      // take a trap this cycle
  output causeT     cause,     // code for the winning fault
  output causeT     mcause     // code of the last trap taken
);

  causeT ecallCause;  // ecall code follows the calling mode

  ////////////////////////////////////////
  // cause select
  ////////////////////////////////////////

  always_comb begin
    case (privMode)
      uMode:   ecallCause = causeEcallU;
      sMode:   ecallCause = causeEcallS;
      default: ecallCause = causeEcallM;  // M, reserved level treated as M
    endcase
  end

  assign trap = fault.illegal | fault.ecall | fault.breakpoint;

  // illegal beats ecall beats ebreak
  // only one of ecall / ebreak can decode, illegal may come from ieu or csr on top
  always_comb begin
    if (fault.illegal)
      cause = causeIllegal;
    else if (fault.ecall)
      cause = ecallCause;
    else if (fault.breakpoint)
      cause = causeBreakpoint;
    else
      cause = '0;  // no trap, value unused
  end

  ////////////////////////////////////////
  // mcause
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      mcause <= '0;
    else if (trap)
      mcause <= cause;  // every trap lands in M
  end

endmodule

//--- verilog/privDec.sv
`timescale 1ns/1ps

module privDec import privPkg::*; #(
  parameter bit sSupported       = 1'b1,
  parameter bit uSupported       = 1'b1,
  parameter bit svinvalSupported = 1'b1,
  parameter int wfiTimeoutBit    = 3
) (
  input  logic       clk,
  input  logic       rstN,
  input  sysFieldT   sysField,    // bits 31:15 of the instruction
  input  logic       privileged,  // SYSTEM privileged op present this cycle
  input  logic       illegalIeu,  // integer unit could not decode it
  input  logic       illegalCsr,  // CSR access not permitted
  input  privModeT   privMode,
  input  privStatusT status,
  output privFaultT  fault,
  output logic       mret,
  output logic       sret,
  output logic       wfi,
  output logic       sfenceVma    // also covers the Svinval forms
);

  // funct12 encodings, all need rs1 == 0
  localparam logic [11:0] f12Ecall         = 12'b0000_0000_0000;
  localparam logic [11:0] f12Ebreak        = 12'b0000_0000_0001;
  localparam logic [11:0] f12Sret          = 12'b0001_0000_0010;
  localparam logic [11:0] f12Mret          = 12'b0011_0000_0010;
  localparam logic [11:0] f12Wfi           = 12'b0001_0000_0101;
  localparam logic [11:0] f12SfenceWInval  = 12'b0001_1000_0000;
  localparam logic [11:0] f12SfenceInvalIr = 12'b0001_1000_0001;
  // funct7 encodings, rs1 / rs2 free
  localparam logic [6:0]  f7SfenceVma      = 7'b0001001;
  localparam logic [6:0]  f7SinvalVma      = 7'b0001011;

  logic [11:0] funct12;
  logic [6:0]  funct7;
  logic        rs1Zero;
  logic        isEcall, isEbreak, isMret, isSret, isWfi;
  logic        isSfence;     // plain sfence.vma
  logic        invalHit;     // any Svinval form, when enabled
  logic        modeM, modeS;
  logic        sretLegal;
  logic        sfenceLegal;
  logic        illegalPriv;  // privileged op matching no legal form
  logic        wfiTimeout;

  ////////////////////////////////////////
  // field match
  ////////////////////////////////////////

  assign funct12 = sysField[31:20];
  assign funct7  = sysField[31:25];
  assign rs1Zero = (sysField[19:15] == 5'd0);

  assign isEcall  = (funct12 == f12Ecall)  & rs1Zero;
  assign isEbreak = (funct12 == f12Ebreak) & rs1Zero;
  assign isMret   = (funct12 == f12Mret)   & rs1Zero;
  assign isSret   = (funct12 == f12Sret)   & rs1Zero;
  assign isWfi    = (funct12 == f12Wfi)    & rs1Zero;
  assign isSfence = (funct7 == f7SfenceVma);

  // Svinval forms behave like sfence.vma here
  assign invalHit = svinvalSupported & ((funct7 == f7SinvalVma) |
                    ((funct12 == f12SfenceWInval)  & rs1Zero) |
                    ((funct12 == f12SfenceInvalIr) & rs1Zero));

  ////////////////////////////////////////
  // mode legality
  ////////////////////////////////////////

  assign modeM = (privMode == mMode);
  assign modeS = (privMode == sMode);

  assign sretLegal   = sSupported & (modeM | (modeS & ~status.tsr));  // TSR traps sret in S
  assign sfenceLegal = modeM | (modeS & ~status.tvm);                 // never from U

  assign mret      = privileged & isMret & modeM;
  assign sret      = privileged & isSret & sretLegal;
  assign wfi       = privileged & isWfi;        // legal in any mode, timeout decides
  assign sfenceVma = privileged & (isSfence | invalHit) & sfenceLegal;

  ////////////////////////////////////////
  // WFI timeout
  ////////////////////////////////////////

  // count consecutive wfi cycles, top bit set on cycle 2^n + 1
  if (uSupported) begin : genWfiTimer
    logic [wfiTimeoutBit:0] wfiCount;

    always_ff @(posedge clk or negedge rstN) begin
      if (!rstN)
        wfiCount <= '0;
      else if (!wfi)
        wfiCount <= '0;  // any other cycle restarts the wait
      else
        wfiCount <= wfiCount + 1'b1;
    end

    // no timeout in M; in S only when TW is set
    assign wfiTimeout = wfi & wfiCount[wfiTimeoutBit] &
                        ((status.tw & ~modeM) | (sSupported & (privMode == uMode)));
  end else begin : genNoWfiTimer
    assign wfiTimeout = 1'b0;  // M-only core, wfi just waits
  end

  ////////////////////////////////////////
  // faults
  ////////////////////////////////////////

  assign illegalPriv = privileged & ~(isEcall | isEbreak | mret | sret | wfi | sfenceVma);

  assign fault.illegal    = illegalIeu | illegalCsr | illegalPriv | wfiTimeout;
  assign fault.ecall      = privileged & isEcall;
  assign fault.breakpoint = privileged & isEbreak;

endmodule

//--- verilog/privPkg.sv
package privPkg;

  ////////////////////////////////////////
  // field widths
  ////////////////////////////////////////

  typedef logic [1:0]   privModeT;   // privilege level, same coding as mstatus.MPP
  typedef logic [3:0]   causeT;      // exception code, interrupt bit not carried
  typedef logic [31:15] sysFieldT;   // funct12 / funct7 plus rs1 of a SYSTEM instr

  // privilege levels
  localparam privModeT uMode = 2'd0;
  localparam privModeT sMode = 2'd1;
  localparam privModeT mMode = 2'd3;  // 2'd2 is reserved

  // synchronous exception codes handled here
  localparam causeT causeIllegal    = 4'd2;
  localparam causeT causeBreakpoint = 4'd3;
  localparam causeT causeEcallU     = 4'd8;
  localparam causeT causeEcallS     = 4'd9;
  localparam causeT causeEcallM     = 4'd11;

  ////////////////////////////////////////
  // grouped signals
  ////////////////////////////////////////

  // status bits that matter to privileged decode and trap entry / return
  typedef struct packed {
    privModeT mpp;  // mode before the last trap
    logic     spp;  // mode before the last S trap, 1 = S
    logic     tsr;  // trap sret in S mode
    logic     tvm;  // trap sfence.vma / satp access in S mode
    logic     tw;   // timeout wait
  } privStatusT;

  // faults raised by the privileged decoder
  typedef struct packed {
    logic illegal;     // illegal instruction from any source
    logic ecall;       // environment call
    logic breakpoint;  // ebreak
  } privFaultT;

endpackage
